/* source/bit_link_if.sv */
`default_nettype none

interface bit_link_if import eeprom_pkg::*; ();

    // sequencer side
    byte_op_e   op;
    logic       op_valid;    // one cycle, only when nothing is pending
    logic [7:0] tx_byte;
    logic       ack_out;     // host ack after a read, 1 = no-ack

    // shifter side
    logic [7:0] rx_byte;
    logic       ack_in;      // slave ack, 0 = acknowledged
    logic       done;        // last cycle of the operation

    modport seq (
        output op,
        output op_valid,
        output tx_byte,
        output ack_out,
        input  rx_byte,
        input  ack_in,
        input  done
    );

    modport shifter (
        input  op,
        input  op_valid,
        input  tx_byte,
        input  ack_out,
        output rx_byte,
        output ack_in,
        output done
    );

endinterface

`default_nettype wire

/* source/byte_shifter.sv */
`default_nettype none

module byte_shifter import eeprom_pkg::*; #(
    parameter int QUARTER_CYCLES = 2
) (
    input  wire          CLK,
    input  wire          RESET,
    bit_link_if.shifter  link,
    output logic         scl,
    output logic         sda_drive_low,
    input  wire          sda_in
);

    localparam int            qw     = (QUARTER_CYCLES > 1) ? $clog2(QUARTER_CYCLES) : 1;
    localparam logic [qw-1:0] q_last = qw'(QUARTER_CYCLES - 1);

    logic          active;
    byte_op_e      op_r;
    logic [7:0]    shreg;
    logic          ack_out_r;
    logic          ack_r;
    logic [3:0]    bit_cnt;     // 0..7 data, 8 ack
    logic [1:0]    phase;       // quarter within the bit
    logic [qw-1:0] qcnt;
    logic          q_end;
    logic          last_bit;
    logic          bit_drive;

    assign q_end = (qcnt == q_last);

    // start and stop are a single bit
    assign last_bit = (op_r == op_write || op_r == op_read) ? (bit_cnt == 4'd8) : 1'b1;

    // sda level for the low phase of the current bit
    always_comb begin
        case (op_r)
            op_write: bit_drive = (bit_cnt == 4'd8) ? 1'b0 : ~shreg[7];
            op_read:  bit_drive = (bit_cnt == 4'd8) ? ~ack_out_r : 1'b0;
            op_stop:  bit_drive = 1'b1;
            default:  bit_drive = 1'b0;  // start needs sda high before scl rises
        endcase
    end

    always_ff @(posedge CLK) begin
        if (RESET) begin
            active        <= 1'b0;
            scl           <= 1'b1;
            sda_drive_low <= 1'b0;
            phase         <= 2'd0;
            qcnt          <= '0;
            bit_cnt       <= 4'd0;
        end else if (!active) begin
            // scl idles high, sda keeps its last level between operations
            if (link.op_valid) begin
                active  <= 1'b1;
                scl     <= 1'b0;
                phase   <= 2'd0;
                qcnt    <= '0;
                bit_cnt <= 4'd0;
            end
        end else begin
            // sda moves one clk after the quarter boundary, clear of the scl edge
            if (qcnt == '0) begin
                if (phase == 2'd0) begin
                    sda_drive_low <= bit_drive;
                end else if (phase == 2'd3 && op_r == op_start) begin
                    sda_drive_low <= 1'b1;   // falling sda, scl high
                end else if (phase == 2'd3 && op_r == op_stop) begin
                    sda_drive_low <= 1'b0;   // rising sda, scl high
                end
            end

            if (q_end) begin
                qcnt  <= '0;
                phase <= phase + 2'd1;
                if (phase == 2'd1) begin
                    scl <= 1'b1;
                end
                if (phase == 2'd3) begin
                    if (last_bit) begin
                        active <= 1'b0;      // scl stays high
                    end else begin
                        scl     <= 1'b0;
                        bit_cnt <= bit_cnt + 4'd1;
                    end
                end
            end else begin
                qcnt <= qcnt + 1'b1;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (!active && link.op_valid) begin
            op_r      <= link.op;
            shreg     <= link.tx_byte;
            ack_out_r <= link.ack_out;
        end else if (active && q_end) begin
            if (phase == 2'd2) begin
                // middle of scl high
                if (op_r == op_read && bit_cnt < 4'd8) begin
                    shreg <= {shreg[6:0], sda_in};
                end
                if (op_r == op_write && bit_cnt == 4'd8) begin
                    ack_r <= sda_in;
                end
            end else if (phase == 2'd3 && op_r == op_write && bit_cnt < 4'd8) begin
                shreg <= {shreg[6:0], 1'b0};  // next bit to msb
            end
        end
    end

    assign link.rx_byte = shreg;
    assign link.ack_in  = ack_r;
    assign link.done    = active && (phase == 2'd3) && q_end && last_bit;

endmodule

`default_nettype wire

/* source/eeprom_host.sv */
`default_nettype none

module eeprom_host import eeprom_pkg::*; #(
    parameter int QUARTER_CYCLES = 2   // clk cycles per quarter of a serial bit
) (
    input  wire              CLK,
    input  wire              RESET,
    input  wire              wr,
    input  wire              rd,
    input  wire [addr_w-1:0] addr,
    input  wire [7:0]        wr_data,
    output logic [7:0]       rd_data,
    output logic             ack,
    output logic             err,
    output logic             busy,
    output logic             scl,
    inout  wire              sda
);

    bit_link_if link ();

    logic sda_drive_low;
    logic sda_in;

    eeprom_seq seq_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .err     (err),
        .busy    (busy),
        .link    (link.seq)
    );

    byte_shifter #(
        .QUARTER_CYCLES (QUARTER_CYCLES)
    ) shifter_inst (
        .CLK           (CLK),
        .RESET         (RESET),
        .link          (link.shifter),
        .scl           (scl),
        .sda_drive_low (sda_drive_low),
        .sda_in        (sda_in)
    );

    // open drain, the pull-up gives the high level
    assign sda    = sda_drive_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

endmodule

`default_nettype wire

/* source/eeprom_pkg.sv */
`default_nettype none

package eeprom_pkg;

    // control byte layout: type code, block bits, r/w bit
    localparam logic [3:0] dev_type = 4'b1010;
    localparam logic       rw_write = 1'b0;
    localparam logic       rw_read  = 1'b1;

    // 2 Kbyte device
    localparam int addr_w = 11;

    // one address word, seen as a memory index or as block plus word byte
    typedef union packed {
        logic [addr_w-1:0] flat;
        struct packed {
            logic [2:0] block;  // goes into the control byte
            logic [7:0] word;   // sent as the address byte
        } split;
    } eeprom_addr_u;

    // op_start is also the repeated start
    typedef enum logic [1:0] {
        op_start,
        op_write,
        op_read,
        op_stop
    } byte_op_e;

endpackage

`default_nettype wire

/* source/eeprom_seq.sv */
`default_nettype none

module eeprom_seq import eeprom_pkg::*; (
    input  wire              CLK,
    input  wire              RESET,
    input  wire              wr,
    input  wire              rd,
    input  wire [addr_w-1:0] addr,
    input  wire [7:0]        wr_data,
    output logic [7:0]       rd_data,
    output logic             ack,
    output logic             err,
    output logic             busy,
    bit_link_if.seq          link
);

    // write list:  start, ctrl, addr, data, stop
    // read list:   start, ctrl, addr, start, ctrl+r, read, stop
    localparam logic [2:0] wr_stop_step = 3'd4;
    localparam logic [2:0] rd_stop_step = 3'd6;

    eeprom_addr_u addr_r;
    logic [7:0]   data_r;
    logic         is_read;
    logic [2:0]   step;
    logic         nacked;
    logic         op_valid_r;
    logic         start_req;
    logic [7:0]   ctrl_wr;
    logic [7:0]   ctrl_rd;

    assign start_req = !busy && (wr || rd);

    assign ctrl_wr = {dev_type, addr_r.split.block, rw_write};
    assign ctrl_rd = {dev_type, addr_r.split.block, rw_read};

    // byte operation for the current step
    always_comb begin
        link.op      = op_stop;
        link.tx_byte = 8'h00;
        case (step)
            3'd0: begin
                link.op = op_start;
            end
            3'd1: begin
                link.op      = op_write;
                link.tx_byte = ctrl_wr;      // dummy write for a read too
            end
            3'd2: begin
                link.op      = op_write;
                link.tx_byte = addr_r.split.word;
            end
            3'd3: begin
                if (is_read) begin
                    link.op = op_start;      // repeated start
                end else begin
                    link.op      = op_write;
                    link.tx_byte = data_r;
                end
            end
            3'd4: begin
                if (is_read) begin
                    link.op      = op_write;
                    link.tx_byte = ctrl_rd;
                end
            end
            3'd5: begin
                link.op = op_read;
            end
            default: begin
                link.op = op_stop;
            end
        endcase
    end

    assign link.op_valid = op_valid_r;
    assign link.ack_out  = 1'b1;  // single byte read, always no-ack

    always_ff @(posedge CLK) begin
        if (RESET) begin
            busy       <= 1'b0;
            ack        <= 1'b0;
            err        <= 1'b0;
            op_valid_r <= 1'b0;
            is_read    <= 1'b0;
            step       <= 3'd0;
            nacked     <= 1'b0;
        end else begin
            ack        <= 1'b0;
            err        <= 1'b0;
            op_valid_r <= 1'b0;
            if (start_req) begin
                busy       <= 1'b1;
                is_read    <= !wr;           // wr wins
                step       <= 3'd0;
                nacked     <= 1'b0;
                op_valid_r <= 1'b1;
            end else if (busy && link.done) begin
                if (link.op == op_stop) begin
                    busy <= 1'b0;
                    ack  <= !nacked;
                    err  <= nacked;
                end else begin
                    if (link.op == op_write && link.ack_in) begin
                        // no device answer, finish with stop
                        nacked <= 1'b1;
                        step   <= is_read ? rd_stop_step : wr_stop_step;
                    end else begin
                        step <= step + 3'd1;
                    end
                    op_valid_r <= 1'b1;
                end
            end
        end
    end

    // request payload
    always_ff @(posedge CLK) begin
        if (start_req) begin
            addr_r.flat <= addr;
            data_r      <= wr_data;
        end
    end

    always_ff @(posedge CLK) begin
        if (busy && link.done && link.op == op_read) begin
            rd_data <= link.rx_byte;
        end
    end

endmodule

`default_nettype wire

/* src.f */
source/eeprom_pkg.sv
source/bit_link_if.sv
source/byte_shifter.sv
source/eeprom_seq.sv
source/eeprom_host.sv
verification/eeprom_model.sv
verification/eeprom_host_props.sv
verification/tb_eeprom_host.sv

/* verification/eeprom_host_props.sv */
`default_nettype none

module eeprom_host_props (
    input wire CLK,
    input wire RESET,
    input wire ack,
    input wire err,
    input wire busy,
    input wire op_valid,
    input wire done
);
    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;
    logic pending;       // op issued and its done not yet seen

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pending <= 1'b0;
        end else if (op_valid) begin
            pending <= 1'b1;
        end else if (done) begin
            pending <= 1'b0;
        end
    end

    ack_err_excl: assert property (@(posedge CLK) disable iff (RESET) !(ack && err))
        else begin
            fail_count++;
            $error("ack and err high in the same cycle");
        end
    ack_pulse: assert property (@(posedge CLK) disable iff (RESET) ack |=> !ack)
        else begin
            fail_count++;
            $error("ack longer than one cycle");
        end
    err_pulse: assert property (@(posedge CLK) disable iff (RESET) err |=> !err)
        else begin
            fail_count++;
            $error("err longer than one cycle");
        end
    // busy drops together with the end pulse
    idle_after_end: assert property (@(posedge CLK) disable iff (RESET) (ack || err) |-> !busy)
        else begin
            fail_count++;
            $error("busy still high with the end pulse");
        end
    op_when_free: assert property (@(posedge CLK) disable iff (RESET) op_valid |-> !pending)
        else begin
            fail_count++;
            $error("op_valid while an operation is pending");
        end

endmodule

bind eeprom_host eeprom_host_props props_inst (
    .CLK      (CLK),
    .RESET    (RESET),
    .ack      (ack),
    .err      (err),
    .busy     (busy),
    .op_valid (link.op_valid),
    .done     (link.done)
);

`default_nettype wire

/* verification/eeprom_model.sv */
`default_nettype none

module eeprom_model import eeprom_pkg::*; (
    input wire scl,
    inout wire sda,
    input wire enable
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0]   mem [0:(1 << addr_w)-1];
    eeprom_addr_u ptr;
    logic [7:0]   shift;
    logic [7:0]   tx;
    logic         active;
    logic         reading;
    logic         go_read;     // read control byte seen
    logic         ack_now;
    logic         sda_low;
    int           bits;        // rising scl edges in this byte
    int           byte_idx;

    assign sda = (sda_low && enable) ? 1'b0 : 1'bz;

    initial begin
        for (int i = 0; i < (1 << addr_w); i++) begin
            mem[i] = 8'hff;  // erased
        end
        active   = 1'b0;
        reading  = 1'b0;
        go_read  = 1'b0;
        sda_low  = 1'b0;
        bits     = 0;
        byte_idx = 0;
    end

    task automatic take_byte;
        ack_now = 1'b1;
        case (byte_idx)
            0: begin
                if (enable && shift[7:4] == dev_type) begin
                    ptr.split.block = shift[3:1];
                    go_read         = shift[0];
                end else begin
                    ack_now = 1'b0;
                    active  = 1'b0;  // not addressed
                end
            end
            1: ptr.split.word = shift;
            default: mem[ptr.flat] = shift;
        endcase
    endtask

    // start and repeated start
    always @(negedge sda) begin
        if (scl === 1'b1) begin
            active   = 1'b1;
            reading  = 1'b0;
            go_read  = 1'b0;
            sda_low  = 1'b0;
            bits     = 0;
            byte_idx = 0;
        end
    end

    always @(posedge sda) begin
        if (scl === 1'b1) begin
            active  = 1'b0;  // stop
            sda_low = 1'b0;
        end
    end

    always @(posedge scl) begin
        if (active) begin
            if (bits < 8 && !reading) begin
                shift = {shift[6:0], sda};
            end
            bits = bits + 1;
            if (bits == 8 && !reading) begin
                take_byte();
            end else if (bits == 9 && reading && sda !== 1'b0) begin
                active = 1'b0;  // host no-ack ends the read
            end
        end
    end

    // sda only moves while scl is low
    always @(negedge scl) begin
        if (active) begin
            if (bits == 8) begin
                sda_low = !reading && ack_now;
            end else if (bits == 9) begin
                bits     = 0;
                byte_idx = byte_idx + 1;
                reading  = go_read;
                tx       = mem[ptr.flat];
                sda_low  = reading && !tx[7];
            end else if (reading && bits > 0) begin
                sda_low = !tx[7 - bits];
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_eeprom_host.sv */
`default_nettype none

module tb_eeprom_host import eeprom_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int end_timeout = 1500;  // clk cycles per transaction

    logic              CLK;
    logic              RESET;
    logic              wr;
    logic              rd;
    logic [addr_w-1:0] addr;
    logic [7:0]        wr_data;
    logic              model_en;
    wire  [7:0]        rd_data;
    wire               ack;
    wire               err;
    wire               busy;
    wire               scl;
    wire               sda;

    logic [7:0] shadow [0:(1 << addr_w)-1];
    bit         written [0:(1 << addr_w)-1];
    integer     seed = 32'h8c84;
    int         error_count = 0;
    int         check_count = 0;
    int         test_count = 0;
    int         errors_at_start = 0;
    int         ack_count = 0;
    logic       cmp_read = 1'b0;
    logic [7:0] cmp_expect;
    string      abort_reason;
    event       abort_run;

    pullup (sda);

    eeprom_host #(
        .QUARTER_CYCLES (2)
    ) eeprom_host_inst (
        .CLK     (CLK),
        .RESET   (RESET),
        .wr      (wr),
        .rd      (rd),
        .addr    (addr),
        .wr_data (wr_data),
        .rd_data (rd_data),
        .ack     (ack),
        .err     (err),
        .busy    (busy),
        .scl     (scl),
        .sda     (sda)
    );

    eeprom_model model_inst (.scl(scl), .sda(sda), .enable(model_en));

    always #2 CLK = ~CLK;

    // last byte written there or the erased value
    function automatic logic [7:0] expected_byte(input eeprom_addr_u a);
        if (written[a.flat]) begin
            return shadow[a.flat];
        end
        return 8'hff;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("ERR %0s: got %0h, expected %0h", name, got, want);
        end
    endtask

    task automatic close_test(input string name);
        test_count++;
        $display("test %0d %0s: %0s", test_count, name,
                 (error_count == errors_at_start) ? "ok" : "mismatch");
        errors_at_start = error_count;
    endtask

    task automatic send_request(input logic is_read, input logic [addr_w-1:0] a,
                                input logic [7:0] d);
        @(posedge CLK);
        wr      <= !is_read;
        rd      <= is_read;
        addr    <= a;
        wr_data <= d;
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_busy;
        int cycles;
        cycles = 0;
        while (busy !== 1'b1) begin
            @(posedge CLK);
            cycles++;
            if (cycles > 20) begin
                abort_reason = "busy did not rise after a request";
                -> abort_run;
                @(posedge CLK);
            end
        end
    endtask

    task automatic wait_end(output logic got_ack, output logic got_err);
        int cycles;
        cycles  = 0;
        got_ack = 1'b0;
        got_err = 1'b0;
        while (!got_ack && !got_err) begin
            @(posedge CLK);
            got_ack = ack;
            got_err = err;
            cycles++;
            if (cycles > end_timeout) begin
                abort_reason = "no ack or err from the controller within the timeout";
                -> abort_run;
                @(posedge CLK);
            end
        end
    endtask

    task automatic transact(input logic is_read, input logic [addr_w-1:0] a,
                            input logic [7:0] d, input logic want_ack);
        logic got_ack;
        logic got_err;
        cmp_read   = is_read;
        cmp_expect = expected_byte(a);
        send_request(is_read, a, d);
        wait_end(got_ack, got_err);
        check_value("ack", got_ack, want_ack);
        check_value("err", got_err, !want_ack);
        if (!is_read && got_ack) begin
            shadow[a]  = d;
            written[a] = 1'b1;
        end
        @(posedge CLK);  // compare process sees the same edge
    endtask

    // read data against the reference
    always @(posedge CLK) begin
        if (ack) begin
            ack_count++;
            if (cmp_read) begin
                check_value("rd_data", rd_data, cmp_expect);
            end
        end
    end

    initial begin
        @(abort_run);
        $display("%0s", abort_reason);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        eeprom_addr_u a;
        logic [7:0]   d;
        logic         is_read;
        logic         got_ack;
        logic         got_err;
        int           acks_before;
        int           assert_fails;

        CLK      = 1'b0;
        RESET    = 1'b1;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wr_data  = 8'h00;
        model_en = 1'b1;
        repeat (3) @(posedge CLK);
        RESET <= 1'b0;
        @(posedge CLK);

        check_value("busy", busy, 0);
        check_value("ack", ack, 0);
        check_value("err", err, 0);
        check_value("scl", scl, 1);
        check_value("sda", sda, 1);
        close_test("idle after reset");

        a.flat = 11'h123;
        transact(1'b0, a, 8'h3c, 1'b1);
        transact(1'b1, a, 8'h00, 1'b1);
        close_test("write then read back");

        for (int b = 0; b < 8; b += 3) begin
            a.split.block = 3'(b);
            a.split.word  = 8'h5a;
            transact(1'b0, a, 8'(8'h10 + b), 1'b1);
        end
        for (int b = 0; b < 8; b += 3) begin
            a.split.block = 3'(b);
            a.split.word  = 8'h5a;
            transact(1'b1, a, 8'h00, 1'b1);
        end
        close_test("block bits");

        for (int i = 0; i < 20; i++) begin
            a.flat  = 11'($random(seed)) & 11'h707;  // small pool for read hits
            d       = 8'($random(seed));
            is_read = 1'($random(seed));
            transact(is_read, a, d, 1'b1);
        end
        close_test("random traffic");

        model_en <= 1'b0;
        a.flat = 11'h2e1;
        transact(1'b0, a, 8'h99, 1'b0);
        transact(1'b1, a, 8'h00, 1'b0);
        model_en <= 1'b1;
        a.flat = 11'h123;
        transact(1'b1, a, 8'h00, 1'b1);
        close_test("no device");

        acks_before = ack_count;
        cmp_read    = 1'b0;
        send_request(1'b0, 11'h444, 8'ha5);
        wait_busy();
        send_request(1'b0, 11'h555, 8'h5a);  // dropped while busy
        wait_end(got_ack, got_err);
        check_value("ack", got_ack, 1);
        shadow[11'h444]  = 8'ha5;
        written[11'h444] = 1'b1;
        repeat (400) @(posedge CLK);  // longer than a whole write
        check_value("ack pulses", ack_count - acks_before, 1);
        transact(1'b1, 11'h444, 8'h00, 1'b1);
        transact(1'b1, 11'h555, 8'h00, 1'b1);
        close_test("requests while busy");

        assert_fails = eeprom_host_inst.props_inst.fail_count;
        $display("tests %0d, checks %0d, errors %0d, assertion failures %0d",
                 test_count, check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
